// File: project.f
+incdir+src
src/OramPkg.sv
src/PathAddressGen.sv
src/SlotScrambler.sv
src/StashController.sv
src/PathOramBackend.sv
tb/ClockGen.sv
tb/DramModel.sv
tb/PathOramBackendTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up in the output
verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module PathOramBackendTb \
	&& ./obj_dir/VPathOramBackendTb | tee /dev/stderr | grep -q "Simulation PASSED" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }

// File: tb/PathOramBackendTb.sv
// Testbench top: stimulus, reference tables, DRAM path observer and checks
// Watchdog and closing summary
`timescale 1ns/1ns
`include "OramDefs.svh"

module PathOramBackendTb
	import OramPkg::*;
();

	localparam int NumDirected = 5;
	localparam int NumRandom = 60;
	localparam int CmdCycles = 300;
	localparam int InitCycles = 100;
	localparam int ClockPeriod = 10;

	logic clock;
	logic reset;
	CommandRequest command;
	logic commandValid;
	logic commandReady;
	logic [`ORAM_D-1:0] loadData;
	logic loadValid;
	logic loadReady;
	logic [`ORAM_D-1:0] storeData;
	logic storeValid;
	logic storeReady;
	DramRequest dramCommand;
	logic dramCommandValid;
	logic dramCommandReady;
	OramBlock dramReadData;
	logic dramReadDataValid;
	logic dramReadDataReady;
	OramBlock dramWriteData;
	logic dramWriteDataValid;
	logic dramWriteDataReady;

	// Reference tables, indexed by block address
	logic [`ORAM_D-1:0] dataTable [1 << `ORAM_U];
	logic [`ORAM_L-1:0] leafTable [1 << `ORAM_U];
	logic present [1 << `ORAM_U];

	// Observer state
	CommandRequest activeReq;
	logic [`ORAM_L-1:0] pathLeafQueue [$];
	logic [`ORAM_SLOT_W-1:0] writeSlotQueue [$];
	OramBlock writeWordQueue [$];
	logic [`ORAM_SLOTS-1:0] initSlots;
	logic readySeen;
	int dramCmdCount;
	int pathStep;
	int errors = 0;
	int checks = 0;
	int seed;

	// Six addresses in use
	logic [`ORAM_U-1:0] addrList [6] = '{6'h03, 6'h11, 6'h1C, 6'h25, 6'h2A, 6'h3E};

	ClockGen clockGen (.clock(clock), .reset(reset));

	PathOramBackend PathOramBackend_inst (
		.clock(clock),
		.reset(reset),
		.command(command),
		.commandValid(commandValid),
		.commandReady(commandReady),
		.loadData(loadData),
		.loadValid(loadValid),
		.loadReady(loadReady),
		.storeData(storeData),
		.storeValid(storeValid),
		.storeReady(storeReady),
		.dramCommand(dramCommand),
		.dramCommandValid(dramCommandValid),
		.dramCommandReady(dramCommandReady),
		.dramReadData(dramReadData),
		.dramReadDataValid(dramReadDataValid),
		.dramReadDataReady(dramReadDataReady),
		.dramWriteData(dramWriteData),
		.dramWriteDataValid(dramWriteDataValid),
		.dramWriteDataReady(dramWriteDataReady)
	);

	DramModel #(.Seed(82)) dram (
		.clock(clock),
		.reset(reset),
		.command(dramCommand),
		.commandValid(dramCommandValid),
		.commandReady(dramCommandReady),
		.readData(dramReadData),
		.readDataValid(dramReadDataValid),
		.readDataReady(dramReadDataReady),
		.writeData(dramWriteData),
		.writeDataValid(dramWriteDataValid),
		.writeDataReady(dramWriteDataReady)
	);

	//------------------------------------------------------------
	// Reference model
	//------------------------------------------------------------

	// Step 0..11 of one access, reads root down, then writes leaf up
	function automatic logic [`ORAM_SLOT_W-1:0] slotOnPath(
		input logic [`ORAM_L-1:0] leaf,
		input int step
	);
		int level;
		int bucket;
		if (step < `ORAM_PATH_SLOTS)
			level = step / 2;
		else
			level = `ORAM_L - (step - `ORAM_PATH_SLOTS) / 2;
		// Heap index under the top level bits of the leaf
		bucket = (1 << level) - 1 + (int'(leaf) >> (`ORAM_L - level));
		return `ORAM_SLOT_W'(bucket * `ORAM_Z + step % 2);
	endfunction

	// Absent block loads as zero
	function automatic logic [`ORAM_D-1:0] referenceLoad(input logic [`ORAM_U-1:0] addr);
		return present[addr] ? dataTable[addr] : '0;
	endfunction

	// Key times odd constant, rotated left by 11, key folded into data
	function automatic OramBlock whiteningMask(input logic [`ORAM_SLOT_W-1:0] slot);
		logic [31:0] product;
		logic [31:0] rotated;
		product = (`ORAM_KEY ^ 32'(slot)) * 32'h2545F491;
		rotated = (product << 11) | (product >> 21);
		return {rotated[8:0], rotated ^ `ORAM_KEY};
	endfunction

	function automatic int randomBelow(input int limit);
		return int'(32'($random(seed)) & 32'h7FFF_FFFF) % limit;
	endfunction

	task automatic flagMismatch(input string name, input logic [63:0] want,
		input logic [63:0] got);
		errors++;
		$display("CHECK FAILED %s: expected %h, got %h at %0t", name, want, got, $time);
	endtask

	task automatic noteProblem(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	//------------------------------------------------------------
	// Compare process, sampled mid-cycle
	//------------------------------------------------------------

	always @(negedge clock) begin
		OramBlock word;
		OramBlock mask;
		OramBlock plain;
		logic [`ORAM_SLOT_W-1:0] slot;
		if (reset) begin
			for (int i = 0; i < (1 << `ORAM_U); i++) begin
				present[i] = 1'b0;
				dataTable[i] = '0;
				leafTable[i] = '0;
			end
			initSlots = '0;
			readySeen = 1'b0;
			dramCmdCount = 0;
			pathStep = 0;
		end else begin
			// Sweep must be complete when ready first shows
			if (commandReady && !readySeen) begin
				readySeen = 1'b1;
				checks++;
				if (dramCmdCount != `ORAM_SLOTS)
					flagMismatch("init write count", `ORAM_SLOTS, 64'(dramCmdCount));
				if (initSlots != '1)
					flagMismatch("init slot map", 64'({`ORAM_SLOTS{1'b1}}), 64'(initSlots));
			end
			if (commandValid && commandReady) begin
				activeReq = command;
				pathLeafQueue.push_back((command.command == CmdAppend) ?
					command.remappedLeaf : command.currentLeaf);
			end
			if (dramCommandValid && dramCommandReady) begin
				checks++;
				if (!readySeen) begin
					if (dramCommand.op != DramWrite)
						noteProblem("DRAM read issued during the init sweep");
					else if (initSlots[dramCommand.slot])
						noteProblem($sformatf("Init sweep wrote slot %0d twice", dramCommand.slot));
					initSlots[dramCommand.slot] = 1'b1;
				end else if (pathLeafQueue.size() == 0) begin
					noteProblem("DRAM command issued with no command in flight");
				end else begin
					if (dramCommand.op != ((pathStep < `ORAM_PATH_SLOTS) ? DramRead : DramWrite))
						flagMismatch("dramCommand.op", 64'(pathStep >= `ORAM_PATH_SLOTS),
							64'(dramCommand.op));
					if (dramCommand.slot != slotOnPath(pathLeafQueue[0], pathStep))
						flagMismatch("dramCommand.slot", 64'(slotOnPath(pathLeafQueue[0], pathStep)),
							64'(dramCommand.slot));
					pathStep++;
					if (pathStep == 2 * `ORAM_PATH_SLOTS) begin
						pathStep = 0;
						void'(pathLeafQueue.pop_front());
					end
				end
				dramCmdCount++;
				if (dramCommand.op == DramWrite)
					writeSlotQueue.push_back(dramCommand.slot);
			end
			if (loadValid && loadReady) begin
				checks++;
				if (loadData !== referenceLoad(activeReq.pAddr))
					flagMismatch("loadData", 64'(referenceLoad(activeReq.pAddr)), 64'(loadData));
				if (present[activeReq.pAddr])
					leafTable[activeReq.pAddr] = activeReq.remappedLeaf;
			end
			if (storeValid && storeReady) begin
				dataTable[activeReq.pAddr] = storeData;
				leafTable[activeReq.pAddr] = activeReq.remappedLeaf;
				present[activeReq.pAddr] = 1'b1;
			end
			if (dramWriteDataValid && dramWriteDataReady)
				writeWordQueue.push_back(dramWriteData);
			// Words pair with write commands in issue order
			while (writeSlotQueue.size() > 0 && writeWordQueue.size() > 0) begin
				slot = writeSlotQueue.pop_front();
				word = writeWordQueue.pop_front();
				mask = whiteningMask(slot);
				plain = word ^ mask;
				checks++;
				if (!plain.valid) begin
					if (plain !== '0)
						flagMismatch("dramWriteData empty block", 64'h0, 64'(plain));
				end else if (!present[plain.pAddr] || plain.data !== dataTable[plain.pAddr] ||
					plain.leaf !== leafTable[plain.pAddr]) begin
					noteProblem($sformatf("Slot %0d got a stale or unknown block for address %h",
						slot, plain.pAddr));
				end
				// Scrambled data field must differ from every stored value
				if (mask.data != '0) begin
					for (int a = 0; a < (1 << `ORAM_U); a++) begin
						if (present[a] && word.data == dataTable[a])
							noteProblem($sformatf("Plaintext data went to DRAM slot %0d", slot));
					end
				end
			end
		end
	end

	//------------------------------------------------------------
	// Stimulus
	//------------------------------------------------------------

	task automatic sendCommand(input BackendCommand kind, input logic [`ORAM_U-1:0] addr,
		input logic [`ORAM_L-1:0] current, input logic [`ORAM_L-1:0] remapped,
		input logic [`ORAM_D-1:0] data);
		@(posedge clock);
		#1;
		command.command = kind;
		command.pAddr = addr;
		command.currentLeaf = current;
		command.remappedLeaf = remapped;
		commandValid = 1'b1;
		storeValid = (kind != CmdRead);
		storeData = data;
		@(negedge clock);
		while (!commandReady)
			@(negedge clock);
		@(posedge clock);
		#1;
		commandValid = 1'b0;
		if (kind == CmdRead) begin
			// Random back-pressure on the load result
			loadReady = 1'($random(seed));
			@(negedge clock);
			while (!(loadValid && loadReady)) begin
				@(posedge clock);
				#1;
				loadReady = 1'($random(seed));
				@(negedge clock);
			end
			@(posedge clock);
			#1;
			loadReady = 1'b0;
		end else begin
			@(negedge clock);
			while (!storeReady)
				@(negedge clock);
			@(posedge clock);
			#1;
			storeValid = 1'b0;
		end
	endtask

	task automatic runRandomMix(input int count);
		logic [`ORAM_U-1:0] addr;
		logic [`ORAM_L-1:0] current;
		BackendCommand kind;
		int pick;
		for (int n = 0; n < count; n++) begin
			addr = addrList[randomBelow(6)];
			pick = randomBelow(3);
			kind = (pick == 0) ? CmdRead : (pick == 1) ? CmdWrite : CmdAppend;
			// Append only for a block that does not exist yet
			if (kind == CmdAppend && present[addr])
				kind = CmdWrite;
			current = present[addr] ? leafTable[addr] : `ORAM_L'($random(seed));
			sendCommand(kind, addr, current, `ORAM_L'($random(seed)), $random(seed));
		end
	endtask

	initial begin
		command = '0;
		commandValid = 1'b0;
		loadReady = 1'b0;
		storeData = '0;
		storeValid = 1'b0;
		seed = 82;
		@(negedge reset);
		// Write then read back, then a never-written address
		sendCommand(CmdWrite, addrList[0], 2'd1, 2'd3, 32'hCAFE_0001);
		sendCommand(CmdRead, addrList[0], leafTable[addrList[0]], 2'd0, '0);
		sendCommand(CmdRead, 6'h30, 2'd2, 2'd1, '0);
		// Append, then read on the appended leaf
		sendCommand(CmdAppend, addrList[1], 2'd0, 2'd2, 32'h5EED_0002);
		sendCommand(CmdRead, addrList[1], leafTable[addrList[1]], 2'd1, '0);
		runRandomMix(NumRandom);
		// Drain the last write-back
		@(negedge clock);
		while (!commandReady || writeSlotQueue.size() != 0)
			@(negedge clock);
		if (pathLeafQueue.size() != 0)
			noteProblem("A path access was left unfinished at the end of the test");
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Per-command bound over all commands, plus the init sweep
	initial begin
		#(((NumDirected + NumRandom) * CmdCycles + InitCycles) * ClockPeriod);
		$display("Watchdog expired, the backend stopped making progress at %0t", $time);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: tb/DramModel.sv
// Slot-addressed DRAM model, in-order command service and read responses
// Random ready and valid back-pressure on all three channels
`timescale 1ns/1ns
`include "OramDefs.svh"

module DramModel
	import OramPkg::*;
#(
	parameter int Seed = 82
) (
	input logic clock,
	input logic reset,
	input DramRequest command,
	input logic commandValid,
	output logic commandReady,
	output OramBlock readData,
	output logic readDataValid,
	input logic readDataReady,
	input OramBlock writeData,
	input logic writeDataValid,
	output logic writeDataReady
);

	OramBlock mem [1 << `ORAM_SLOT_W];
	DramRequest cmdQueue [$];
	OramBlock wordQueue [$];
	OramBlock respQueue [$];
	logic consumed;
	int seed;

	//------------------------------------------------------------
	// Transfers, sampled mid-cycle
	//------------------------------------------------------------

	always @(negedge clock) begin
		if (reset) begin
			cmdQueue.delete();
			wordQueue.delete();
			respQueue.delete();
			consumed = 1'b0;
		end else begin
			consumed = readDataValid && readDataReady;
			if (consumed)
				void'(respQueue.pop_front());
			if (commandValid && commandReady)
				cmdQueue.push_back(command);
			if (writeDataValid && writeDataReady)
				wordQueue.push_back(writeData);
			// Reads wait behind older writes, so the path read sees committed data
			while (cmdQueue.size() > 0) begin
				if (cmdQueue[0].op == DramWrite) begin
					if (wordQueue.size() == 0)
						break;
					mem[cmdQueue[0].slot] = wordQueue.pop_front();
				end else begin
					respQueue.push_back(mem[cmdQueue[0].slot]);
				end
				void'(cmdQueue.pop_front());
			end
		end
	end

	//------------------------------------------------------------
	// Output drive, 1 ns after the rising edge
	//------------------------------------------------------------

	initial begin
		seed = Seed;
		commandReady = 1'b0;
		writeDataReady = 1'b0;
		readDataValid = 1'b0;
		readData = '0;
		// Fill pattern tied to the slot, never a valid block
		for (int i = 0; i < (1 << `ORAM_SLOT_W); i++) begin
			mem[i] = '0;
			mem[i].data = 32'hA5A5_0000 | 32'(i);
		end
		forever begin
			@(posedge clock);
			#1;
			if (reset) begin
				commandReady = 1'b0;
				writeDataReady = 1'b0;
				readDataValid = 1'b0;
			end else begin
				commandReady = 1'($random(seed));
				writeDataReady = 1'($random(seed));
				// Offered word stays put until taken
				if (!readDataValid || consumed) begin
					readDataValid = (respQueue.size() > 0) && 1'($random(seed));
					if (readDataValid)
						readData = respQueue[0];
				end
			end
		end
	end

endmodule

// File: tb/ClockGen.sv
// Testbench clock and power-on reset
`timescale 1ns/1ns

module ClockGen (
	output logic clock,
	output logic reset
);

	// 10 ns period
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Reset over the first two rising edges
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

// File: src/PathOramBackend.sv
// Backend top level, address generation, scrambler and stash
`timescale 1ns/1ns
`include "OramDefs.svh"

module PathOramBackend
	import OramPkg::*;
(
	input logic clock,
	input logic reset,

	// Frontend
	input CommandRequest command,
	input logic commandValid,
	output logic commandReady,
	output logic [`ORAM_D-1:0] loadData,
	output logic loadValid,
	input logic loadReady,
	input logic [`ORAM_D-1:0] storeData,
	input logic storeValid,
	output logic storeReady,

	// DRAM
	output DramRequest dramCommand,
	output logic dramCommandValid,
	input logic dramCommandReady,
	input OramBlock dramReadData,
	input logic dramReadDataValid,
	output logic dramReadDataReady,
	output OramBlock dramWriteData,
	output logic dramWriteDataValid,
	input logic dramWriteDataReady
);

	//------------------------------------------------------------
	// Stage links
	//------------------------------------------------------------

	PathPhase phase;
	logic phaseValid;
	logic evictDone;

	PathWord stashRead;
	logic stashReadValid;
	logic stashReadReady;
	PathWord stashWrite;
	logic stashWriteValid;
	logic stashWriteReady;

	PathAddressGen addrGen (
		.clock(clock),
		.reset(reset),
		.request(command),
		.requestValid(commandValid),
		.requestReady(commandReady),
		.dramCmd(dramCommand),
		.dramCmdValid(dramCommandValid),
		.dramCmdReady(dramCommandReady),
		.phase(phase),
		.phaseValid(phaseValid),
		.evictDone(evictDone),
		.initDone()
	);

	// Read slots tagged as their commands reach DRAM
	SlotScrambler scrambler (
		.clock(clock),
		.reset(reset),
		.readIn(dramReadData),
		.readInValid(dramReadDataValid),
		.readInReady(dramReadDataReady),
		.readSlot('{push: dramCommandValid && dramCommandReady &&
			(dramCommand.op == DramRead), slot: dramCommand.slot}),
		.readOut(stashRead),
		.readOutValid(stashReadValid),
		.readOutReady(stashReadReady),
		.writeIn(stashWrite),
		.writeInValid(stashWriteValid),
		.writeInReady(stashWriteReady),
		.writeOut(dramWriteData),
		.writeOutValid(dramWriteDataValid),
		.writeOutReady(dramWriteDataReady)
	);

	StashController stash (
		.clock(clock),
		.reset(reset),
		.phase(phase),
		.phaseValid(phaseValid),
		.evictDone(evictDone),
		.request(command),
		.readIn(stashRead),
		.readInValid(stashReadValid),
		.readInReady(stashReadReady),
		.writeOut(stashWrite),
		.writeOutValid(stashWriteValid),
		.writeOutReady(stashWriteReady),
		.loadData(loadData),
		.loadValid(loadValid),
		.loadReady(loadReady),
		.storeData(storeData),
		.storeValid(storeValid),
		.storeReady(storeReady)
	);

endmodule

// File: src/StashController.sv
// Stash storage, lookup and request service
// Remapping and greedy write-back along the evicted path
`timescale 1ns/1ns
`include "OramDefs.svh"

module StashController
	import OramPkg::*;
(
	input logic clock,
	input logic reset,
	input PathPhase phase,
	input logic phaseValid,
	output logic evictDone,
	input CommandRequest request,
	input PathWord readIn,
	input logic readInValid,
	output logic readInReady,
	output PathWord writeOut,
	output logic writeOutValid,
	input logic writeOutReady,
	output logic [`ORAM_D-1:0] loadData,
	output logic loadValid,
	input logic loadReady,
	input logic [`ORAM_D-1:0] storeData,
	input logic storeValid,
	output logic storeReady
);

	localparam int IdxW = $clog2(`ORAM_STASH);

	typedef enum logic [2:0] {
		StInit,
		StIdle,
		StAbsorb,
		StService,
		StEvict
	} StashState;

	StashState state;
	OramBlock stash [`ORAM_STASH];
	CommandRequest req;
	logic [`ORAM_L-1:0] evictLeaf;
	logic [3:0] initCount;
	logic [2:0] pathCount;

	logic [IdxW-1:0] freeIdx;
	logic freeFound;
	logic [IdxW-1:0] hitIdx;
	logic hitFound;
	logic [IdxW-1:0] pickIdx;
	logic pickFound;
	int evictLevel;

	// Block may sit at this level if the top level bits of both leaves agree
	function automatic logic eligible(
		input logic [`ORAM_L-1:0] blockLeaf,
		input logic [`ORAM_L-1:0] target,
		input int level
	);
		return ((blockLeaf ^ target) >> (`ORAM_L - level)) == '0;
	endfunction

	//------------------------------------------------------------
	// Stash search
	//------------------------------------------------------------

	assign evictLevel = `ORAM_L - int'(pathCount >> 1);

	always_comb begin
		freeIdx = '0;
		freeFound = 1'b0;
		hitIdx = '0;
		hitFound = 1'b0;
		pickIdx = '0;
		pickFound = 1'b0;
		// Lowest index wins in each search
		for (int i = 0; i < `ORAM_STASH; i++) begin
			if (!stash[i].valid && !freeFound) begin
				freeIdx = IdxW'(i);
				freeFound = 1'b1;
			end
			if (stash[i].valid && stash[i].pAddr == req.pAddr && !hitFound) begin
				hitIdx = IdxW'(i);
				hitFound = 1'b1;
			end
			if (stash[i].valid && !pickFound &&
				eligible(stash[i].leaf, evictLeaf, evictLevel)) begin
				pickIdx = IdxW'(i);
				pickFound = 1'b1;
			end
		end
	end

	//------------------------------------------------------------
	// Outputs
	//------------------------------------------------------------

	assign readInReady = (state == StAbsorb);
	assign loadValid = (state == StService) && (req.command == CmdRead);
	assign storeReady = (state == StService) && (req.command != CmdRead);
	// Absent block reads as zero
	assign loadData = hitFound ? stash[hitIdx].data : '0;
	assign writeOutValid = (state == StInit) || (state == StEvict);

	always_comb begin
		writeOut.slot = initCount;
		writeOut.block = '0;
		if (state == StEvict) begin
			// Empty slot gets an invalid block
			writeOut.slot = pathSlot(evictLeaf, evictLevel, pathCount[0]);
			if (pickFound)
				writeOut.block = stash[pickIdx];
		end
	end

	//------------------------------------------------------------
	// Control
	//------------------------------------------------------------

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= StInit;
			initCount <= '0;
			pathCount <= '0;
			evictDone <= 1'b0;
			for (int i = 0; i < `ORAM_STASH; i++)
				stash[i].valid <= 1'b0;
		end else begin
			evictDone <= 1'b0;
			case (state)
				StInit: begin
					// Empty word for every slot
					if (writeOutReady) begin
						initCount <= initCount + 4'd1;
						if (initCount == `ORAM_SLOTS - 1) begin
							// Last empty word handed on
							evictDone <= 1'b1;
							state <= StIdle;
						end
					end
				end
				StIdle: begin
					if (phaseValid && phase.marker == PhaseAccept) begin
						pathCount <= '0;
						state <= StAbsorb;
					end
				end
				StAbsorb: begin
					if (readInValid) begin
						// Only real blocks enter the stash
						if (readIn.block.valid && freeFound)
							stash[freeIdx] <= readIn.block;
						pathCount <= pathCount + 3'd1;
						if (pathCount == `ORAM_PATH_SLOTS - 1)
							state <= StService;
					end
				end
				StService: begin
					if (req.command == CmdRead) begin
						if (loadReady) begin
							if (hitFound)
								stash[hitIdx].leaf <= req.remappedLeaf;
							pathCount <= '0;
							state <= StEvict;
						end
					end else if (storeValid) begin
						// Overwrite in place or take a free entry
						if (hitFound) begin
							stash[hitIdx].data <= storeData;
							stash[hitIdx].leaf <= req.remappedLeaf;
						end else if (freeFound) begin
							stash[freeIdx].valid <= 1'b1;
							stash[freeIdx].pAddr <= req.pAddr;
							stash[freeIdx].leaf <= req.remappedLeaf;
							stash[freeIdx].data <= storeData;
						end
						pathCount <= '0;
						state <= StEvict;
					end
				end
				StEvict: begin
					if (writeOutReady) begin
						if (pickFound)
							stash[pickIdx].valid <= 1'b0;
						pathCount <= pathCount + 3'd1;
						if (pathCount == `ORAM_PATH_SLOTS - 1) begin
							evictDone <= 1'b1;
							state <= StIdle;
						end
					end
				end
				default: begin
					state <= StIdle;
				end
			endcase
		end
	end

	//------------------------------------------------------------
	// Payload registers
	//------------------------------------------------------------

	// Command sampled on its transfer edge
	always_ff @(posedge clock) begin
		if (phaseValid && phase.marker == PhaseAccept)
			req <= request;
		if (phaseValid && phase.marker == PhaseReadDone)
			evictLeaf <= phase.leaf;
	end

	// Overflow recovery not supported
	stashRoom: assert property (@(posedge clock) disable iff (reset)
		(readInValid && readInReady && readIn.block.valid) |-> freeFound)
		else $error("Stash full on path read");

endmodule

// File: src/SlotScrambler.sv
// Address-keyed whitening for both DRAM directions
// Read slot FIFO pairing returning words with their slots
`timescale 1ns/1ns
`include "OramDefs.svh"

module SlotScrambler
	import OramPkg::*;
(
	input logic clock,
	input logic reset,
	input OramBlock readIn,
	input logic readInValid,
	output logic readInReady,
	input SlotTag readSlot,
	output PathWord readOut,
	output logic readOutValid,
	input logic readOutReady,
	input PathWord writeIn,
	input logic writeInValid,
	output logic writeInReady,
	output OramBlock writeOut,
	output logic writeOutValid,
	input logic writeOutReady
);

	logic [`ORAM_SLOT_W-1:0] slotFifo [8];
	logic [2:0] wrPtr;
	logic [2:0] rdPtr;
	logic [3:0] fifoCount;
	logic readFire;
	logic [`ORAM_SLOT_W-1:0] headSlot;

	// Multiply, rotate, then fold the key back in
	function automatic OramBlock slotMask(input logic [`ORAM_SLOT_W-1:0] slot);
		logic [31:0] mix;
		logic [31:0] rot;
		mix = (`ORAM_KEY ^ 32'(slot)) * 32'h2545F491;
		rot = {mix[20:0], mix[31:21]};
		return OramBlock'({rot[8:0], rot ^ `ORAM_KEY});
	endfunction

	//------------------------------------------------------------
	// Read slot FIFO
	//------------------------------------------------------------

	assign readFire = readInValid && readInReady;
	assign headSlot = slotFifo[rdPtr];

	always_ff @(posedge clock) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fifoCount <= '0;
		end else begin
			if (readSlot.push)
				wrPtr <= wrPtr + 3'd1;
			if (readFire)
				rdPtr <= rdPtr + 3'd1;
			fifoCount <= fifoCount + 4'(readSlot.push) - 4'(readFire);
		end
	end

	always_ff @(posedge clock) begin
		if (readSlot.push)
			slotFifo[wrPtr] <= readSlot.slot;
	end

	//------------------------------------------------------------
	// Read lane, DRAM to stash
	//------------------------------------------------------------

	// Stall when the output register is held
	assign readInReady = !readOutValid || readOutReady;

	always_ff @(posedge clock) begin
		if (reset)
			readOutValid <= 1'b0;
		else if (readInReady)
			readOutValid <= readInValid;
	end

	always_ff @(posedge clock) begin
		if (readFire) begin
			readOut.slot <= headSlot;
			readOut.block <= readIn ^ slotMask(headSlot);
		end
	end

	//------------------------------------------------------------
	// Write lane, stash to DRAM
	//------------------------------------------------------------

	assign writeInReady = !writeOutValid || writeOutReady;

	always_ff @(posedge clock) begin
		if (reset)
			writeOutValid <= 1'b0;
		else if (writeInReady)
			writeOutValid <= writeInValid;
	end

	always_ff @(posedge clock) begin
		if (writeInValid && writeInReady)
			writeOut <= writeIn.block ^ slotMask(writeIn.slot);
	end

	// Every returning word needs an issued read behind it
	readHasSlot: assert property (@(posedge clock) disable iff (reset)
		readInValid |-> fifoCount != 0)
		else $error("DRAM read data with empty slot FIFO");

endmodule

// File: src/PathAddressGen.sv
// Slot command sequencer for the init sweep and per-command path accesses
`timescale 1ns/1ns
`include "OramDefs.svh"

module PathAddressGen
	import OramPkg::*;
(
	input logic clock,
	input logic reset,
	input CommandRequest request,
	input logic requestValid,
	output logic requestReady,
	output DramRequest dramCmd,
	output logic dramCmdValid,
	input logic dramCmdReady,
	output PathPhase phase,
	output logic phaseValid,
	input logic evictDone,
	output logic initDone
);

	typedef enum logic [2:0] {
		Init,
		Idle,
		ReadPath,
		WaitStash,
		WritePath
	} GenState;

	GenState state;
	logic [3:0] slotCount;
	logic [`ORAM_L-1:0] pathLeaf;
	logic evictSeen;
	logic cmdFire;

	//------------------------------------------------------------
	// Command and phase outputs
	//------------------------------------------------------------

	assign requestReady = (state == Idle) && initDone;
	assign cmdFire = dramCmdValid && dramCmdReady;

	always_comb begin
		dramCmd.op = DramWrite;
		dramCmd.slot = slotCount;
		dramCmdValid = 1'b0;
		case (state)
			Init: begin
				dramCmdValid = slotCount < `ORAM_SLOTS;
			end
			ReadPath: begin
				// Root first, slot 0 before slot 1
				dramCmd.op = DramRead;
				dramCmd.slot = pathSlot(pathLeaf, int'(slotCount >> 1), slotCount[0]);
				dramCmdValid = 1'b1;
			end
			WritePath: begin
				// Leaf bucket first
				dramCmd.slot = pathSlot(pathLeaf, `ORAM_L - int'(slotCount >> 1),
					slotCount[0]);
				dramCmdValid = slotCount < `ORAM_PATH_SLOTS;
			end
			default: begin
				dramCmdValid = 1'b0;
			end
		endcase
	end

	// Accept pulse lets the stash sample the command on the transfer edge
	always_comb begin
		if (state == WaitStash) begin
			phase.marker = PhaseReadDone;
			phase.leaf = pathLeaf;
			phaseValid = 1'b1;
		end else begin
			phase.marker = PhaseAccept;
			phase.leaf = (request.command == CmdAppend) ?
				request.remappedLeaf : request.currentLeaf;
			phaseValid = requestValid && requestReady;
		end
	end

	//------------------------------------------------------------
	// Sequencer
	//------------------------------------------------------------

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= Init;
			slotCount <= '0;
			initDone <= 1'b0;
			evictSeen <= 1'b0;
		end else begin
			if (evictDone)
				evictSeen <= 1'b1;
			case (state)
				Init: begin
					if (cmdFire)
						slotCount <= slotCount + 4'd1;
					// Sweep ends when all slots issued and the stash is done
					if (slotCount == `ORAM_SLOTS && (evictSeen || evictDone)) begin
						slotCount <= '0;
						initDone <= 1'b1;
						state <= Idle;
					end
				end
				Idle: begin
					if (requestValid && requestReady) begin
						slotCount <= '0;
						evictSeen <= 1'b0;
						state <= ReadPath;
					end
				end
				ReadPath: begin
					if (cmdFire) begin
						slotCount <= slotCount + 4'd1;
						if (slotCount == `ORAM_PATH_SLOTS - 1) begin
							slotCount <= '0;
							state <= WaitStash;
						end
					end
				end
				WaitStash: begin
					state <= WritePath;
				end
				WritePath: begin
					if (cmdFire)
						slotCount <= slotCount + 4'd1;
					// Done once all writes issued and the stash drained
					if (slotCount == `ORAM_PATH_SLOTS && (evictSeen || evictDone))
						state <= Idle;
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

	// Path leaf only changes on accept
	always_ff @(posedge clock) begin
		if (requestValid && requestReady)
			pathLeaf <= phase.leaf;
	end

	// Only the init sweep may run before init completes
	initOrder: assert property (@(posedge clock) disable iff (reset)
		(dramCmdValid && state != Init) |-> initDone)
		else $error("DRAM command before init sweep finished");

endmodule

// File: src/OramPkg.sv
// Command, DRAM and phase types shared by the backend stages
// Path slot address helper
`include "OramDefs.svh"

package OramPkg;

	// Frontend command encoding
	typedef enum logic [1:0] {
		CmdRead,
		CmdWrite,
		CmdAppend
	} BackendCommand;

	typedef enum logic {
		DramRead,
		DramWrite
	} DramOp;

	// Stash to address generator handshake markers
	typedef enum logic {
		PhaseAccept,
		PhaseReadDone
	} PhaseMarker;

	typedef struct packed {
		BackendCommand command;
		logic [`ORAM_U-1:0] pAddr;
		logic [`ORAM_L-1:0] currentLeaf;
		logic [`ORAM_L-1:0] remappedLeaf;
	} CommandRequest;

	// Stash entry and plaintext DRAM word
	typedef struct packed {
		logic valid;
		logic [`ORAM_U-1:0] pAddr;
		logic [`ORAM_L-1:0] leaf;
		logic [`ORAM_D-1:0] data;
	} OramBlock;

	typedef struct packed {
		DramOp op;
		logic [`ORAM_SLOT_W-1:0] slot;
	} DramRequest;

	// Word passed between the stages
	typedef struct packed {
		logic [`ORAM_SLOT_W-1:0] slot;
		OramBlock block;
	} PathWord;

	// Slot of a read command as it enters DRAM
	typedef struct packed {
		logic push;
		logic [`ORAM_SLOT_W-1:0] slot;
	} SlotTag;

	typedef struct packed {
		PhaseMarker marker;
		logic [`ORAM_L-1:0] leaf;
	} PathPhase;

	// Heap index of the node at this level, times bucket size, plus slot
	function automatic logic [`ORAM_SLOT_W-1:0] pathSlot(
		input logic [`ORAM_L-1:0] leaf,
		input int level,
		input logic sel
	);
		int bucket;
		bucket = (1 << level) - 1 + int'(leaf >> (`ORAM_L - level));
		return `ORAM_SLOT_W'(bucket * `ORAM_Z + int'(sel));
	endfunction

endpackage

// File: src/OramDefs.svh
// Tree geometry, widths and scrambling key for the Path ORAM backend
`ifndef ORAM_DEFS_SVH
`define ORAM_DEFS_SVH

// Tree depth, three levels and four leaves
`define ORAM_L 2

// Blocks per bucket
`define ORAM_Z 2

// Block address and data widths
`define ORAM_U 6
`define ORAM_D 32

// DRAM slot address width, 14 slots in use
`define ORAM_SLOT_W 4
`define ORAM_SLOTS 14

// Slots on one root to leaf path
`define ORAM_PATH_SLOTS 6

// Stash entries
`define ORAM_STASH 8

// Whitening key
`define ORAM_KEY 32'h9E3779B9

`endif
